//--- Makefile
VERILATOR ?= verilator
TOP ?= boxingGameTb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FLIST))
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	$(BINARY) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
verilog/displayPkg.sv
verilog/gamePkg.sv
verilog/segmentDecoder.sv
verilog/scoreKeeper.sv
verilog/roundTimer.sv
verilog/poseDatapath.sv
verilog/poseSequencer.sv
verilog/boxingGame.sv
test/boxingGame_assertions.sv
test/boxingGameTb.sv

//--- test/boxingGameTb.sv
`timescale 1ns/1ps

module boxingGameTb;
	import gamePkg::*;

	// shortened frame and timing so a full round fits in a short run
	localparam int width = 8;
	localparam int height = 6;
	localparam int topRow = 2;
	localparam int secondCycles = 10;
	localparam int holdCycles = 12;
	localparam int resetCycles = 10;
	localparam int cycleLimit = resetCycles + (3 * roundSeconds * secondCycles) / 2;
	localparam logic [31:0] lfsrTaps = 32'h8020_0003;

	logic CLOCK_50 = 1'b0;
	logic reset;
	logic [3:1] KEY;
	logic [1:0] LEDR;
	displayPkg::segments HEX0, HEX1, HEX4, HEX5;
	displayPkg::pixelX pixelX;
	displayPkg::pixelY pixelY;
	displayPkg::pixelAddress address;
	imageCode image;
	logic pixelWrite;
	logic [31:0] lfsr = 32'h359a;
	int cycleCount = 0;

	boxingGame #(.screenWidth(width), .screenHeight(height), .poseTopRow(topRow),
		.cyclesPerSecond(secondCycles), .poseHoldCycles(holdCycles)) dut (.*);

	always #20 CLOCK_50 = ~CLOCK_50;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] advanceLfsr(input logic [31:0] value);
		advanceLfsr = (value >> 1) ^ (value[0] ? lfsrTaps : 32'h0);
	endfunction

	// one LFSR step per bit taken
	task automatic takeBits(input int count, output int bits);
		bits = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = advanceLfsr(lfsr);
			bits = (bits << 1) | int'(lfsr[0]);
		end
	endtask

	// active low segments, bit 0 is segment a
	function automatic displayPkg::segments digitPattern(input int value);
		case (value)
			0: digitPattern = 7'b100_0000;
			1: digitPattern = 7'b111_1001;
			2: digitPattern = 7'b010_0100;
			3: digitPattern = 7'b011_0000;
			4: digitPattern = 7'b001_1001;
			5: digitPattern = 7'b001_0010;
			6: digitPattern = 7'b000_0010;
			7: digitPattern = 7'b111_1000;
			8: digitPattern = 7'b000_0000;
			9: digitPattern = 7'b001_1000;
			default: digitPattern = 7'b111_1111;
		endcase
	endfunction

	task automatic stopWithError(input string message);
		$display("%s", message);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	// --------------------------------------------------
	// failure watch and timeout
	// --------------------------------------------------
	always @(posedge CLOCK_50)
	begin
		cycleCount <= cycleCount + 1;
		if (dut.checks.failed === 1'b1)
			stopWithError($sformatf("ERR %0t: bound assertion failed, see error above", $time));
		else if (cycleCount >= cycleLimit)
			stopWithError($sformatf("timeout: no game over after %0d cycles", cycleCount));
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial
	begin
		int bits;
		int score;
		reset = 1'b0;
		KEY = 3'b111;
		repeat (resetCycles) @(posedge CLOCK_50);
		#2 reset = 1'b1;
		// idle a while before the start key
		repeat (5) @(posedge CLOCK_50);
		#2 KEY[1] = 1'b0;
		@(posedge CLOCK_50);
		#2 KEY[1] = 1'b1;
		while (dut.sequencer.state != gameOver)
		begin
			@(posedge CLOCK_50);
			#2;
			takeBits(4, bits);
			// a one cycle punch now and then, center or right
			if (bits[3:1] == 3'd0)
				KEY[3:2] = bits[0] ? 2'b10 : 2'b01;
			else
				KEY[3:2] = 2'b11;
		end
		KEY = 3'b111;
		repeat (5) @(posedge CLOCK_50);
		#2;
		score = dut.checks.modelScore;
		if (dut.checks.failed !== 1'b0 || dut.checks.endDrawn !== 1'b1)
			stopWithError("end screen was not drawn or a bound assertion failed");
		else if (HEX1 !== digitPattern(roundSeconds / 10)
			|| HEX0 !== digitPattern(roundSeconds % 10)
			|| HEX5 !== digitPattern(score / 10) || HEX4 !== digitPattern(score % 10))
			stopWithError($sformatf("ERR %0t: digits %b %b %b %b wrong for score %0d",
				$time, HEX5, HEX4, HEX1, HEX0, score));
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

//--- test/boxingGame_assertions.sv
`timescale 1ns/1ps

module boxingGameAssertions #(
	parameter int screenWidth = displayPkg::screenWidth,
	parameter int screenHeight = displayPkg::screenHeight,
	parameter int poseTopRow = displayPkg::poseTopRow,
	parameter int cyclesPerSecond = gamePkg::cyclesPerSecond,
	parameter int roundSeconds = gamePkg::roundSeconds
) (
	input logic CLOCK_50,
	input logic reset,
	input logic [3:1] KEY,
	input logic [1:0] LEDR,
	input logic start,
	input logic punchCenter,
	input logic punchRight,
	input logic waiting,
	input logic frameRestart,
	input logic pixelWrite,
	input displayPkg::pixelX pixelX,
	input displayPkg::pixelY pixelY,
	input displayPkg::pixelAddress address,
	input gamePkg::imageCode image,
	input displayPkg::segments HEX4,
	input displayPkg::segments HEX5,
	input gamePkg::bcdDigit scoreOnes,
	input gamePkg::bcdDigit scoreTens,
	input gamePkg::bcdDigit secondsOnes,
	input gamePkg::bcdDigit secondsTens
);
	import gamePkg::*;

	localparam int roundCycles = roundSeconds * cyclesPerSecond;
	localparam logic [6:0] zeroPattern = 7'b100_0000;

	logic started, lastWrite, endDrawn, hitPending, missPending;
	logic [1:0] poseIndex;
	int writeCount, modelCycles, modelScore;
	logic isPose, keyCorrect, keyWrong, expectHit, expectMiss, frameStart;
	int frameWrites, firstRow;
	imageCode expectedImage;
	logic failIdle, failPixel, failStart, failLength, failScore, failSeconds, failEnd;
	logic failEcho;
	logic failed;

	initial
	begin
		failIdle = 1'b0;
		failPixel = 1'b0;
		failStart = 1'b0;
		failLength = 1'b0;
		failScore = 1'b0;
		failSeconds = 1'b0;
		failEnd = 1'b0;
		failEcho = 1'b0;
	end

	assign failed = failIdle | failPixel | failStart | failLength | failScore |
		failSeconds | failEnd | failEcho;

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------

	// center pose wants the center key, right and left want the right key
	assign isPose = image inside {poseCenter, poseRight, poseLeft};
	assign keyCorrect = (image == poseCenter) ? punchCenter : punchRight;
	assign keyWrong = (image == poseCenter) ? punchRight : punchCenter;
	assign expectHit = waiting && isPose && keyCorrect;
	assign expectMiss = waiting && isPose && !keyCorrect && keyWrong;
	assign frameStart = pixelWrite && (writeCount == 0);
	assign firstRow = (image == endScreen) ? 0 : poseTopRow;
	assign frameWrites = (image == endScreen) ? screenWidth * screenHeight :
		screenWidth * (screenHeight - poseTopRow);

	always_comb
	begin
		if (hitPending)
			expectedImage = hitFlash;
		else if (missPending)
			expectedImage = missFlash;
		else if (poseIndex == 2'd1)
			expectedImage = poseRight;
		else if (poseIndex == 2'd3)
			expectedImage = poseLeft;
		else
			expectedImage = poseCenter;
	end

	always_ff @(posedge CLOCK_50)
	begin
		lastWrite <= reset && pixelWrite;
		if (!reset || frameRestart)
			writeCount <= 0;
		else if (pixelWrite)
			writeCount <= writeCount + 1;
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!reset || start)
		begin
			// a start key marks the round as begun, a reset does not
			started <= reset;
			modelCycles <= 0;
			modelScore <= 0;
			poseIndex <= 2'd0;
			hitPending <= 1'b0;
			missPending <= 1'b0;
			endDrawn <= 1'b0;
		end
		else
		begin
			if (started && modelCycles < roundCycles)
				modelCycles <= modelCycles + 1;
			if (expectHit && modelScore < 99)
				modelScore <= modelScore + 1;
			else if (expectMiss && modelScore > 0)
				modelScore <= modelScore - 1;
			// a flash restarts the pose order
			if (frameStart)
			begin
				hitPending <= 1'b0;
				missPending <= 1'b0;
				poseIndex <= (hitPending || missPending) ? 2'd0 : poseIndex + 2'd1;
			end
			else if (expectHit)
				hitPending <= 1'b1;
			else if (expectMiss)
				missPending <= 1'b1;
			if (lastWrite && !pixelWrite && image == endScreen)
				endDrawn <= 1'b1;
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	quietBeforeStart: assert property (@(posedge CLOCK_50) disable iff (!reset)
		!started |-> !pixelWrite && HEX4 == zeroPattern && HEX5 == zeroPattern)
	else
	begin
		failIdle = 1'b1;
		$error("pixel write or nonzero score before start");
	end

	// pressed keys pull the pins low, LEDR lights for center on bit 0
	punchEcho: assert property (@(posedge CLOCK_50) disable iff (!reset)
		LEDR == {!KEY[3], !KEY[2]})
	else
	begin
		failEcho = 1'b1;
		$error("LEDR does not echo the punch keys");
	end

	pixelInFrame: assert property (@(posedge CLOCK_50) disable iff (!reset)
		pixelWrite |-> address == 16'(writeCount) && int'(pixelX) < screenWidth
			&& int'(pixelY) < screenHeight)
	else
	begin
		failPixel = 1'b1;
		$error("address step or pixel position wrong");
	end

	frameOpening: assert property (@(posedge CLOCK_50) disable iff (!reset)
		frameStart |-> pixelX == '0 && int'(pixelY) == firstRow && ((image == endScreen) ?
			(modelCycles == roundCycles && !hitPending && !missPending) :
			(image == expectedImage)))
	else
	begin
		failStart = 1'b1;
		$error("frame opened with wrong image or first pixel");
	end

	frameLength: assert property (@(posedge CLOCK_50) disable iff (!reset)
		lastWrite && !pixelWrite |-> writeCount == frameWrites)
	else
	begin
		failLength = 1'b1;
		$error("frame write count wrong");
	end

	scoreTracks: assert property (@(posedge CLOCK_50) disable iff (!reset)
		int'(scoreTens) * 10 + int'(scoreOnes) == modelScore && scoreOnes <= 4'd9)
	else
	begin
		failScore = 1'b1;
		$error("score digits differ from model");
	end

	secondsTrack: assert property (@(posedge CLOCK_50) disable iff (!reset)
		int'(secondsTens) * 10 + int'(secondsOnes) == modelCycles / cyclesPerSecond
			&& secondsOnes <= 4'd9)
	else
	begin
		failSeconds = 1'b1;
		$error("seconds digits differ from model");
	end

	quietAfterEnd: assert property (@(posedge CLOCK_50) disable iff (!reset)
		endDrawn |-> !pixelWrite)
	else
	begin
		failEnd = 1'b1;
		$error("pixel write after end screen");
	end

endmodule

bind boxingGame boxingGameAssertions #(.screenWidth(screenWidth),
	.screenHeight(screenHeight), .poseTopRow(poseTopRow),
	.cyclesPerSecond(cyclesPerSecond)) checks (.*);

//--- verilog/boxingGame.sv
`timescale 1ns/1ps

module boxingGame #(
	parameter int screenWidth = displayPkg::screenWidth,
	parameter int screenHeight = displayPkg::screenHeight,
	parameter int poseTopRow = displayPkg::poseTopRow,
	parameter int cyclesPerSecond = gamePkg::cyclesPerSecond,
	parameter int poseHoldCycles = gamePkg::poseHoldCycles
) (
	input logic CLOCK_50,
	input logic reset,
	input logic [3:1] KEY,
	output logic [1:0] LEDR,
	output displayPkg::segments HEX0,
	output displayPkg::segments HEX1,
	output displayPkg::segments HEX4,
	output displayPkg::segments HEX5,
	output displayPkg::pixelX pixelX,
	output displayPkg::pixelY pixelY,
	output displayPkg::pixelAddress address,
	output gamePkg::imageCode image,
	output logic pixelWrite
);
	import gamePkg::*;

	logic start, punchCenter, punchRight;
	logic frameRestart, fullFrame, drawing, waiting;
	logic frameDone, waitDone, roundOver;
	logic hitPulse, missPulse;
	bcdDigit secondsOnes, secondsTens, scoreOnes, scoreTens;

	// keys are active low
	assign start = ~KEY[1];
	assign punchCenter = ~KEY[2];
	assign punchRight = ~KEY[3];
	assign LEDR = {punchRight, punchCenter};

	poseSequencer sequencer (.CLOCK_50, .reset, .start, .punchCenter, .punchRight,
		.frameDone, .waitDone, .roundOver, .frameRestart, .fullFrame, .drawing,
		.waiting, .hitPulse, .missPulse, .image);

	poseDatapath #(.screenWidth(screenWidth), .screenHeight(screenHeight),
		.poseTopRow(poseTopRow), .poseHoldCycles(poseHoldCycles)) datapath (
		.CLOCK_50, .reset, .frameRestart, .fullFrame, .drawing, .waiting,
		.pixelX, .pixelY, .address, .pixelWrite, .frameDone, .waitDone);

	roundTimer #(.cyclesPerSecond(cyclesPerSecond), .roundSeconds(roundSeconds)) timer (
		.CLOCK_50, .reset, .start, .secondsOnes, .secondsTens, .roundOver);

	scoreKeeper score (.CLOCK_50, .reset, .start, .hitPulse, .missPulse,
		.scoreOnes, .scoreTens);

	// seconds on the right, score on the left
	segmentDecoder secondsOnesDigit (.digit(secondsOnes), .pattern(HEX0));
	segmentDecoder secondsTensDigit (.digit(secondsTens), .pattern(HEX1));
	segmentDecoder scoreOnesDigit (.digit(scoreOnes), .pattern(HEX4));
	segmentDecoder scoreTensDigit (.digit(scoreTens), .pattern(HEX5));

endmodule

//--- verilog/displayPkg.sv
package displayPkg;

	// --------------------------------------------------
	// screen geometry
	// --------------------------------------------------

	// pixels per row
	localparam int screenWidth = 320;

	// rows per frame
	localparam int screenHeight = 240;

	// first row of pose, hit and miss frames
	localparam int poseTopRow = 75;

	// --------------------------------------------------
	// pixel stream types
	// --------------------------------------------------

	typedef logic [8:0] pixelX;
	typedef logic [7:0] pixelY;

	// sprite memory address, restarts at 0 every frame
	typedef logic [15:0] pixelAddress;

	// active low, bit 0 is segment a
	typedef logic [6:0] segments;

endpackage

//--- verilog/gamePkg.sv
package gamePkg;

	// --------------------------------------------------
	// timing defaults
	// --------------------------------------------------

	localparam int cyclesPerSecond = 50_000_000;

	// two seconds per pose, hit or miss frame
	localparam int poseHoldCycles = 100_000_000;

	localparam int roundSeconds = 60;

	// --------------------------------------------------
	// game types
	// --------------------------------------------------

	typedef logic [3:0] bcdDigit;

	// sprite selection sent out with the pixel stream
	typedef enum logic [2:0] {
		endScreen = 3'd0,
		poseCenter = 3'd1,
		poseRight = 3'd2,
		poseLeft = 3'd3,
		hitFlash = 3'd4,
		missFlash = 3'd6
	} imageCode;

	typedef enum logic [4:0] {
		gameStart, nextPose,
		drawCenter, drawRight, drawCenterAgain, drawLeft,
		holdCenter, holdRight, holdCenterAgain, holdLeft,
		drawHit, holdHit,
		drawMiss, holdMiss,
		drawEnd, gameOver
	} sequencerState;

endpackage

//--- verilog/poseDatapath.sv
`timescale 1ns/1ps

module poseDatapath #(
	parameter int screenWidth = displayPkg::screenWidth,
	parameter int screenHeight = displayPkg::screenHeight,
	parameter int poseTopRow = displayPkg::poseTopRow,
	parameter int poseHoldCycles = gamePkg::poseHoldCycles
) (
	input logic CLOCK_50,
	input logic reset,
	input logic frameRestart,
	input logic fullFrame,
	input logic drawing,
	input logic waiting,
	output displayPkg::pixelX pixelX,
	output displayPkg::pixelY pixelY,
	output displayPkg::pixelAddress address,
	output logic pixelWrite,
	output logic frameDone,
	output logic waitDone
);
	localparam logic [8:0] lastColumn = 9'(screenWidth - 1);
	localparam logic [7:0] firstRow = 8'(poseTopRow);
	localparam logic [7:0] endRow = 8'(screenHeight);
	localparam int holdBits = $clog2(poseHoldCycles + 1);
	localparam logic [holdBits-1:0] holdLast = holdBits'(poseHoldCycles);

	logic [holdBits-1:0] holdCount;

	// --------------------------------------------------
	// raster scan
	// --------------------------------------------------
	assign pixelWrite = drawing && (pixelY < endRow);
	assign frameDone = (pixelY == endRow);

	always_ff @(posedge CLOCK_50)
	begin
		if (!reset)
		begin
			pixelX <= '0;
			pixelY <= endRow;
			address <= '0;
		end
		else if (frameRestart)
		begin
			pixelX <= '0;
			pixelY <= fullFrame ? 8'd0 : firstRow;
			address <= '0;
		end
		else if (pixelWrite)
		begin
			address <= address + 16'd1;
			// wrap to the next row right after the last column
			if (pixelX == lastColumn)
			begin
				pixelX <= '0;
				pixelY <= pixelY + 8'd1;
			end
			else
				pixelX <= pixelX + 9'd1;
		end
	end

	// --------------------------------------------------
	// hold timer
	// --------------------------------------------------
	assign waitDone = (holdCount == holdLast);

	always_ff @(posedge CLOCK_50)
	begin
		if (!reset || frameRestart)
			holdCount <= '0;
		else if (waiting && !waitDone)
			holdCount <= holdCount + 1'b1;
	end

endmodule

//--- verilog/poseSequencer.sv
`timescale 1ns/1ps

module poseSequencer (
	input logic CLOCK_50,
	input logic reset,
	input logic start,
	input logic punchCenter,
	input logic punchRight,
	input logic frameDone,
	input logic waitDone,
	input logic roundOver,
	output logic frameRestart,
	output logic fullFrame,
	output logic drawing,
	output logic waiting,
	output logic hitPulse,
	output logic missPulse,
	output gamePkg::imageCode image
);
	import gamePkg::*;

	sequencerState state, nextState;
	sequencerState poseAfter;
	logic correctKey, wrongKey;

	// --------------------------------------------------
	// key judging for the current hold
	// --------------------------------------------------
	always_comb
	begin
		correctKey = punchCenter;
		wrongKey = punchRight;
		poseAfter = drawRight;
		case (state)
			holdRight:
			begin
				correctKey = punchRight;
				wrongKey = punchCenter;
				poseAfter = drawCenterAgain;
			end
			holdCenterAgain:
				poseAfter = drawLeft;
			holdLeft:
			begin
				// left pose is answered with the right key too
				correctKey = punchRight;
				wrongKey = punchCenter;
				poseAfter = nextPose;
			end
			default:
				poseAfter = drawRight;
		endcase
	end

	// --------------------------------------------------
	// next state and punch pulses
	// --------------------------------------------------
	always_comb
	begin
		nextState = state;
		hitPulse = 1'b0;
		missPulse = 1'b0;
		case (state)
			gameStart, gameOver:
				if (start)
					nextState = nextPose;
			nextPose:
				nextState = roundOver ? drawEnd : drawCenter;
			drawCenter:
				if (frameDone)
					nextState = holdCenter;
			drawRight:
				if (frameDone)
					nextState = holdRight;
			drawCenterAgain:
				if (frameDone)
					nextState = holdCenterAgain;
			drawLeft:
				if (frameDone)
					nextState = holdLeft;
			holdCenter, holdRight, holdCenterAgain, holdLeft:
			begin
				if (correctKey)
				begin
					hitPulse = 1'b1;
					nextState = drawHit;
				end
				else if (wrongKey)
				begin
					missPulse = 1'b1;
					nextState = drawMiss;
				end
				else if (waitDone)
					nextState = poseAfter;
				else if (roundOver)
					nextState = drawEnd;
			end
			drawHit:
				if (frameDone)
					nextState = holdHit;
			drawMiss:
				if (frameDone)
					nextState = holdMiss;
			holdHit, holdMiss:
				if (waitDone)
					nextState = nextPose;
			drawEnd:
				if (frameDone)
					nextState = gameOver;
			default:
				nextState = gameStart;
		endcase
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!reset)
			state <= gameStart;
		else
			state <= nextState;
	end

	// restart the raster on every move into a draw or hold state
	assign frameRestart = (nextState != state) &&
		!(nextState inside {gameStart, nextPose, gameOver});
	assign fullFrame = (nextState == drawEnd);

	assign drawing = state inside {drawCenter, drawRight, drawCenterAgain, drawLeft,
		drawHit, drawMiss, drawEnd};
	assign waiting = state inside {holdCenter, holdRight, holdCenterAgain, holdLeft,
		holdHit, holdMiss};

	// hold keeps showing the pose just drawn
	always_comb
	begin
		case (state)
			drawRight, holdRight:
				image = poseRight;
			drawLeft, holdLeft:
				image = poseLeft;
			drawHit, holdHit:
				image = hitFlash;
			drawMiss, holdMiss:
				image = missFlash;
			drawEnd, gameOver:
				image = endScreen;
			default:
				image = poseCenter;
		endcase
	end

endmodule

//--- verilog/roundTimer.sv
`timescale 1ns/1ps

module roundTimer #(
	parameter int cyclesPerSecond = gamePkg::cyclesPerSecond,
	parameter int roundSeconds = gamePkg::roundSeconds
) (
	input logic CLOCK_50,
	input logic reset,
	input logic start,
	output gamePkg::bcdDigit secondsOnes,
	output gamePkg::bcdDigit secondsTens,
	output logic roundOver
);
	import gamePkg::*;

	localparam int tickBits = $clog2(cyclesPerSecond);
	localparam logic [tickBits-1:0] tickLast = tickBits'(cyclesPerSecond - 1);
	localparam bcdDigit endOnes = bcdDigit'(roundSeconds % 10);
	localparam bcdDigit endTens = bcdDigit'(roundSeconds / 10);

	logic [tickBits-1:0] prescale;
	logic running;
	logic tick;

	assign tick = (prescale == tickLast);
	assign roundOver = (secondsTens == endTens) && (secondsOnes == endOnes);

	// counting begins with the first start and freezes at the round length
	always_ff @(posedge CLOCK_50)
	begin
		if (!reset)
		begin
			prescale <= '0;
			secondsOnes <= '0;
			secondsTens <= '0;
			running <= 1'b0;
		end
		else if (start)
		begin
			prescale <= '0;
			secondsOnes <= '0;
			secondsTens <= '0;
			running <= 1'b1;
		end
		else if (running && !roundOver)
		begin
			prescale <= tick ? '0 : prescale + 1'b1;
			if (tick)
			begin
				// carry into the tens digit at nine
				if (secondsOnes == 4'd9)
				begin
					secondsOnes <= 4'd0;
					secondsTens <= secondsTens + 4'd1;
				end
				else
					secondsOnes <= secondsOnes + 4'd1;
			end
		end
	end

endmodule

//--- verilog/scoreKeeper.sv
`timescale 1ns/1ps

module scoreKeeper (
	input logic CLOCK_50,
	input logic reset,
	input logic start,
	input logic hitPulse,
	input logic missPulse,
	output gamePkg::bcdDigit scoreOnes,
	output gamePkg::bcdDigit scoreTens
);
	logic atTop, atBottom;

	// saturation limits, 99 and 00
	assign atTop = (scoreTens == 4'd9) && (scoreOnes == 4'd9);
	assign atBottom = (scoreTens == 4'd0) && (scoreOnes == 4'd0);

	always_ff @(posedge CLOCK_50)
	begin
		if (!reset || start)
		begin
			scoreOnes <= 4'd0;
			scoreTens <= 4'd0;
		end
		else if (hitPulse && !atTop)
		begin
			if (scoreOnes == 4'd9)
			begin
				scoreOnes <= 4'd0;
				scoreTens <= scoreTens + 4'd1;
			end
			else
				scoreOnes <= scoreOnes + 4'd1;
		end
		else if (missPulse && !atBottom)
		begin
			// borrow from the tens digit
			if (scoreOnes == 4'd0)
			begin
				scoreOnes <= 4'd9;
				scoreTens <= scoreTens - 4'd1;
			end
			else
				scoreOnes <= scoreOnes - 4'd1;
		end
	end

endmodule

//--- verilog/segmentDecoder.sv
`timescale 1ns/1ps

module segmentDecoder (
	input gamePkg::bcdDigit digit,
	output displayPkg::segments pattern
);
	// pattern bits run g down to a, low lights a segment
	always_comb
	begin
		case (digit)
			4'h0: pattern = 7'b100_0000;
			4'h1: pattern = 7'b111_1001;
			4'h2: pattern = 7'b010_0100;
			4'h3: pattern = 7'b011_0000;
			4'h4: pattern = 7'b001_1001;
			4'h5: pattern = 7'b001_0010;
			4'h6: pattern = 7'b000_0010;
			4'h7: pattern = 7'b111_1000;
			4'h8: pattern = 7'b000_0000;
			4'h9: pattern = 7'b001_1000;
			4'hA: pattern = 7'b000_1000;
			4'hB: pattern = 7'b000_0011;
			4'hC: pattern = 7'b100_0110;
			4'hD: pattern = 7'b010_0001;
			4'hE: pattern = 7'b000_0110;
			4'hF: pattern = 7'b000_1110;
			default: pattern = 7'b111_1111;
		endcase
	end

endmodule
